// File: conv_in_pkg.sv
package conv_in_pkg;

	// stream widths
	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;
	localparam int LEN_W = 12;

	// dispatch message layout
	localparam int MSG_W = 8;
	localparam int TGT_W = 3;
	localparam int INFO_W = 2;
	localparam int INFO_LSB = 3;
	// one-hot target bits
	localparam int TGT_FT = 2;
	localparam int TGT_KERNEL = 1;
	localparam int TGT_LINEAR = 0;
	// bits inside the packet info
	localparam int INFO_VALID = 1;
	// last-row flag for rows, A/B select for linear, zero for kernels
	localparam int INFO_AUX = 0;

	// message queue
	localparam int MSG_FIFO_DEPTH = 4;
	localparam int MSG_FIFO_PTR_W = $clog2(MSG_FIFO_DEPTH);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [KEEP_W-1:0] keep_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [MSG_W-1:0] dispatch_msg_t;
	typedef logic [TGT_W-1:0] tgt_t;
	typedef logic [INFO_W-1:0] pkt_info_t;
	typedef logic [MSG_FIFO_PTR_W-1:0] msg_ptr_t;
	// one extra bit so a full queue can be told from an empty one
	typedef logic [MSG_FIFO_PTR_W:0] msg_cnt_t;

	typedef enum logic [1:0] {CMD_FT_ROW, CMD_KERNEL, CMD_LINEAR_A, CMD_LINEAR_B} cmd_kind_e;
	typedef enum logic {ST_IDLE, ST_REQ} rd_ctrl_state_e;

endpackage

// File: dispatch_msg_fifo.sv
`timescale 1ns/1ps

module dispatch_msg_fifo
	import conv_in_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// write side, from the read controller
	input dispatch_msg_t push_msg,
	input logic push_en,
	output logic full,
	// read side, towards the gateway
	output dispatch_msg_t msg,
	output logic msg_valid,
	input logic msg_ready
);

	// circular message store
	dispatch_msg_t mem [MSG_FIFO_DEPTH];
	msg_ptr_t wr_ptr;
	msg_ptr_t rd_ptr;
	msg_cnt_t count;
	logic do_push;
	logic do_pop;

	// writes into a full queue are dropped
	assign do_push = push_en & ~full;
	assign do_pop = msg_valid & msg_ready;

	assign full = (count == msg_cnt_t'(MSG_FIFO_DEPTH));
	assign msg_valid = (count != '0);
	// head comes straight out of the storage flops
	// and cannot be overwritten before it pops, since writes stop when full
	assign msg = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_msg;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave the count alone
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;
		end
	end

endmodule

// File: conv_in_rd_ctrl.sv
`timescale 1ns/1ps

module conv_in_rd_ctrl
	import conv_in_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// load command
	input cmd_kind_e cmd_kind,
	input logic cmd_valid_pkt,
	input logic cmd_last_row,
	input len_t cmd_len,
	input logic cmd_valid,
	output logic cmd_ready,
	// read request to the DMA
	output len_t dma_req_len,
	output logic dma_req_valid,
	input logic dma_req_ready,
	// message queue write side
	input logic full,
	output dispatch_msg_t push_msg,
	output logic push_en
);

	rd_ctrl_state_e state;
	rd_ctrl_state_e state_nxt;
	len_t len_q;
	logic cmd_acc;
	tgt_t tgt;
	pkt_info_t info;

	// one command in flight at a time, and only with room for its message
	assign cmd_ready = (state == ST_IDLE) & ~full;
	assign cmd_acc = cmd_valid & cmd_ready;

	// target and packet info from the command kind
	always_comb begin
		tgt = '0;
		info = '0;
		info[INFO_VALID] = cmd_valid_pkt;
		case (cmd_kind)
			CMD_FT_ROW: begin
				tgt[TGT_FT] = 1'b1;
				info[INFO_AUX] = cmd_last_row;
			end
			CMD_KERNEL: tgt[TGT_KERNEL] = 1'b1;
			CMD_LINEAR_A: tgt[TGT_LINEAR] = 1'b1;
			CMD_LINEAR_B: begin
				tgt[TGT_LINEAR] = 1'b1;
				// type bit set for parameter set B
				info[INFO_AUX] = 1'b1;
			end
			default: tgt = '0;
		endcase
	end

	// reserved bits stay zero
	always_comb begin
		push_msg = '0;
		push_msg[TGT_W-1:0] = tgt;
		push_msg[INFO_LSB +: INFO_W] = info;
	end

	// message goes in on the accept edge, valid or not
	assign push_en = cmd_acc;

	always_comb begin
		state_nxt = state;
		case (state)
			// invalid packets never leave idle
			ST_IDLE: if (cmd_acc && cmd_valid_pkt) state_nxt = ST_REQ;
			ST_REQ: if (dma_req_ready) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) state <= ST_IDLE;
		else state <= state_nxt;
	end

	// word count held for the whole request
	always_ff @(posedge clk) begin
		if (cmd_acc && cmd_valid_pkt) len_q <= cmd_len;
	end

	assign dma_req_valid = (state == ST_REQ);
	assign dma_req_len = len_q;

endmodule

// File: axis_gateway_for_conv_in.sv
`timescale 1ns/1ps

module axis_gateway_for_conv_in
	import conv_in_pkg::*;
(
	// dispatch message from the queue head
	input dispatch_msg_t msg,
	input logic msg_valid,
	output logic msg_ready,
	// DMA read stream
	input data_t dma_data,
	input keep_t dma_keep,
	input logic dma_last,
	input logic dma_valid,
	output logic dma_ready,
	// feature map row buffer
	output data_t ft_data,
	output logic ft_last,
	output pkt_info_t ft_user,
	output logic ft_valid,
	input logic ft_ready,
	// kernel buffer
	output data_t kernel_data,
	output keep_t kernel_keep,
	output logic kernel_last,
	output logic kernel_user,
	output logic kernel_valid,
	input logic kernel_ready,
	// linear parameter buffer
	output data_t linear_data,
	output keep_t linear_keep,
	output logic linear_last,
	output pkt_info_t linear_user,
	output logic linear_valid,
	input logic linear_ready
);

	tgt_t tgt;
	pkt_info_t info;
	tgt_t out_ready;
	logic pkt_valid;
	logic sel_ready;
	logic beat_avail;
	logic out_last;

	// message decode
	assign tgt = msg[TGT_W-1:0];
	assign info = msg[INFO_LSB +: INFO_W];
	assign pkt_valid = info[INFO_VALID];

	// ready of the output the message points at
	assign out_ready[TGT_FT] = ft_ready;
	assign out_ready[TGT_KERNEL] = kernel_ready;
	assign out_ready[TGT_LINEAR] = linear_ready;
	assign sel_ready = |(tgt & out_ready);

	// invalid packet makes its marker beat without any DMA data
	assign beat_avail = msg_valid & (~pkt_valid | dma_valid);
	// marker beat is a packet of one
	assign out_last = ~pkt_valid | dma_last;

	// DMA only moves for valid packets
	assign dma_ready = msg_valid & sel_ready & pkt_valid;
	// message pops with the last DMA beat, or alone for a marker
	assign msg_ready = sel_ready & (~pkt_valid | (dma_valid & dma_last));

	// feature rows carry the full info
	assign ft_data = dma_data;
	assign ft_last = out_last;
	assign ft_user = info;
	assign ft_valid = beat_avail & tgt[TGT_FT];

	// kernels see only the valid bit
	assign kernel_data = dma_data;
	// no bytes enabled on a zero kernel
	assign kernel_keep = {KEEP_W{pkt_valid}} & dma_keep;
	assign kernel_last = out_last;
	assign kernel_user = pkt_valid;
	assign kernel_valid = beat_avail & tgt[TGT_KERNEL];

	// linear params, info holds the A/B type
	assign linear_data = dma_data;
	assign linear_keep = dma_keep;
	assign linear_last = out_last;
	assign linear_user = info;
	assign linear_valid = beat_avail & tgt[TGT_LINEAR];

endmodule

// File: conv_in_loader.sv
`timescale 1ns/1ps

module conv_in_loader
	import conv_in_pkg::*;
(
	input logic clk,
	input logic rst_n,
	// load commands
	input cmd_kind_e cmd_kind,
	input logic cmd_valid_pkt,
	input logic cmd_last_row,
	input len_t cmd_len,
	input logic cmd_valid,
	output logic cmd_ready,
	// DMA read request
	output len_t dma_req_len,
	output logic dma_req_valid,
	input logic dma_req_ready,
	// DMA read stream
	input data_t dma_data,
	input keep_t dma_keep,
	input logic dma_last,
	input logic dma_valid,
	output logic dma_ready,
	// feature map output
	output data_t ft_data,
	output logic ft_last,
	output pkt_info_t ft_user,
	output logic ft_valid,
	input logic ft_ready,
	// kernel output
	output data_t kernel_data,
	output keep_t kernel_keep,
	output logic kernel_last,
	output logic kernel_user,
	output logic kernel_valid,
	input logic kernel_ready,
	// linear parameter output
	output data_t linear_data,
	output keep_t linear_keep,
	output logic linear_last,
	output pkt_info_t linear_user,
	output logic linear_valid,
	input logic linear_ready
);

	// control to queue
	dispatch_msg_t push_msg;
	logic push_en;
	logic full;
	// queue to gateway
	dispatch_msg_t msg;
	logic msg_valid;
	logic msg_ready;

	conv_in_rd_ctrl rd_ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_kind(cmd_kind),
		.cmd_valid_pkt(cmd_valid_pkt),
		.cmd_last_row(cmd_last_row),
		.cmd_len(cmd_len),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.dma_req_len(dma_req_len),
		.dma_req_valid(dma_req_valid),
		.dma_req_ready(dma_req_ready),
		.full(full),
		.push_msg(push_msg),
		.push_en(push_en)
	);

	dispatch_msg_fifo msg_fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push_msg(push_msg),
		.push_en(push_en),
		.full(full),
		.msg(msg),
		.msg_valid(msg_valid),
		.msg_ready(msg_ready)
	);

	axis_gateway_for_conv_in gateway_inst (
		.msg(msg),
		.msg_valid(msg_valid),
		.msg_ready(msg_ready),
		.dma_data(dma_data),
		.dma_keep(dma_keep),
		.dma_last(dma_last),
		.dma_valid(dma_valid),
		.dma_ready(dma_ready),
		.ft_data(ft_data),
		.ft_last(ft_last),
		.ft_user(ft_user),
		.ft_valid(ft_valid),
		.ft_ready(ft_ready),
		.kernel_data(kernel_data),
		.kernel_keep(kernel_keep),
		.kernel_last(kernel_last),
		.kernel_user(kernel_user),
		.kernel_valid(kernel_valid),
		.kernel_ready(kernel_ready),
		.linear_data(linear_data),
		.linear_keep(linear_keep),
		.linear_last(linear_last),
		.linear_user(linear_user),
		.linear_valid(linear_valid),
		.linear_ready(linear_ready)
	);

endmodule

// File: conv_in_loader_asserts.sv
`timescale 1ns/1ps

module conv_in_loader_asserts
	import conv_in_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input len_t dma_req_len,
	input logic dma_req_valid,
	input logic dma_req_ready,
	input data_t ft_data,
	input logic ft_last,
	input pkt_info_t ft_user,
	input logic ft_valid,
	input logic ft_ready,
	input data_t kernel_data,
	input keep_t kernel_keep,
	input logic kernel_last,
	input logic kernel_user,
	input logic kernel_valid,
	input logic kernel_ready,
	input data_t linear_data,
	input keep_t linear_keep,
	input logic linear_last,
	input pkt_info_t linear_user,
	input logic linear_valid,
	input logic linear_ready
);

	// failure count, read by the testbench at the end
	int fired = 0;

	// a stalled beat keeps valid and payload, marker data is don't care
	assert property (@(posedge clk) disable iff (!rst_n)
		ft_valid && !ft_ready |=> ft_valid && $stable({ft_last, ft_user})
			&& (!ft_user[INFO_VALID] || $stable(ft_data)))
	else begin
		fired++;
		$error("ft beat changed while stalled");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		kernel_valid && !kernel_ready |=> kernel_valid
			&& $stable({kernel_last, kernel_user, kernel_keep})
			&& (!kernel_user || $stable(kernel_data)))
	else begin
		fired++;
		$error("kernel beat changed while stalled");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		linear_valid && !linear_ready |=> linear_valid && $stable({linear_last, linear_user})
			&& (!linear_user[INFO_VALID] || $stable({linear_data, linear_keep})))
	else begin
		fired++;
		$error("linear beat changed while stalled");
	end

	// request held with its length until the DMA takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		dma_req_valid && !dma_req_ready |=> dma_req_valid && $stable(dma_req_len))
	else begin
		fired++;
		$error("DMA request dropped or changed while stalled");
	end

	// one message at the head, so one output at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ft_valid, kernel_valid, linear_valid}))
	else begin
		fired++;
		$error("more than one output valid");
	end

	// every valid comes from a register that a reset edge clears
	assert property (@(posedge clk)
		!rst_n |=> !(ft_valid || kernel_valid || linear_valid || dma_req_valid))
	else begin
		fired++;
		$error("valid high after a reset edge");
	end

endmodule

bind conv_in_loader conv_in_loader_asserts asserts_inst (.*);

// File: tb_conv_in_loader.sv
`timescale 1ns/1ps

module tb_conv_in_loader
	import conv_in_pkg::*;
();

	localparam int MAX_CMD = 32;
	// cycles any single wait may take
	localparam int TIMEOUT = 1000;

	// one expected output beat
	typedef struct packed {
		data_t data;
		keep_t keep;
		pkt_info_t user;
		logic last;
		logic has_data;
	} exp_beat_t;

	logic clk;
	logic rst_n;
	cmd_kind_e cmd_kind;
	logic cmd_valid_pkt;
	logic cmd_last_row;
	len_t cmd_len;
	logic cmd_valid;
	logic cmd_ready;
	len_t dma_req_len;
	logic dma_req_valid;
	logic dma_req_ready;
	data_t dma_data;
	keep_t dma_keep;
	logic dma_last;
	logic dma_valid;
	logic dma_ready;
	data_t ft_data;
	pkt_info_t ft_user;
	logic ft_last;
	logic ft_valid;
	logic ft_ready;
	data_t kernel_data;
	keep_t kernel_keep;
	logic kernel_last;
	logic kernel_user;
	logic kernel_valid;
	logic kernel_ready;
	data_t linear_data;
	keep_t linear_keep;
	pkt_info_t linear_user;
	logic linear_last;
	logic linear_valid;
	logic linear_ready;

	// command list from the stim file
	cmd_kind_e c_kind [MAX_CMD];
	logic c_valid [MAX_CMD];
	logic c_last [MAX_CMD];
	len_t c_len [MAX_CMD];
	data_t c_base [MAX_CMD];
	int n_cmd = 0;

	exp_beat_t ft_q[$];
	exp_beat_t kernel_q[$];
	exp_beat_t linear_q[$];
	int err_count = 0;
	int req_seen = 0;
	// a raised request not yet taken by the DMA
	logic req_open = 1'b0;
	logic bp_en = 1'b0;
	logic aborted = 1'b0;

	conv_in_loader conv_in_loader_inst (.*);

	always #10 clk = ~clk;

	function automatic logic pick_ready();
		if (!bp_en) return 1'b1;
		// ready three cycles out of four
		return ($urandom % 4) != 0;
	endfunction

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_info(input string name, input pkt_info_t exp, input pkt_info_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_keep(input string name, input keep_t exp, input keep_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_len(input string name, input len_t exp, input len_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			err_count++;
		end
	endtask

	task automatic load_stim();
		int fd;
		int k;
		int v;
		int lr;
		int ln;
		data_t base;
		string line;
		fd = $fopen("conv_in_stim.txt", "r");
		if (fd == 0) begin
			$display("stimulus file conv_in_stim.txt could not be opened");
			aborted = 1'b1;
		end else begin
			while (!$feof(fd) && n_cmd < MAX_CMD) begin
				// comment and blank lines fail the scan and are skipped
				if ($fgets(line, fd) != 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d %h", k, v, lr, ln, base) == 5) begin
						c_kind[n_cmd] = cmd_kind_e'(k[1:0]);
						c_valid[n_cmd] = (v != 0);
						c_last[n_cmd] = (lr != 0);
						c_len[n_cmd] = len_t'(ln);
						c_base[n_cmd] = base;
						n_cmd++;
					end
				end
			end
			$fclose(fd);
			if (n_cmd == 0) begin
				$display("no commands found in conv_in_stim.txt");
				aborted = 1'b1;
			end
		end
	endtask

	// expected beats of command i, on the output its kind names
	task automatic expect_cmd(input int i);
		exp_beat_t e;
		int beats;
		// invalid command gives a single marker beat
		beats = c_valid[i] ? int'(c_len[i]) : 1;
		for (int b = 0; b < beats; b++) begin
			e.data = c_base[i] + data_t'(b);
			e.has_data = c_valid[i];
			e.last = (b == beats - 1);
			e.keep = (c_kind[i] == CMD_KERNEL && !c_valid[i]) ? '0 : '1;
			case (c_kind[i])
				CMD_FT_ROW: e.user = {c_valid[i], c_last[i]};
				CMD_KERNEL: e.user = {1'b0, c_valid[i]};
				CMD_LINEAR_A: e.user = {c_valid[i], 1'b0};
				default: e.user = {c_valid[i], 1'b1};
			endcase
			if (c_kind[i] == CMD_FT_ROW) ft_q.push_back(e);
			else if (c_kind[i] == CMD_KERNEL) kernel_q.push_back(e);
			else linear_q.push_back(e);
		end
	endtask

	task automatic take_beat(input int port, input data_t data, input keep_t keep,
			input pkt_info_t user, input logic last);
		exp_beat_t e;
		logic got;
		string name;
		name = (port == 0) ? "ft" : ((port == 1) ? "kernel" : "linear");
		got = 1'b1;
		if (port == 0 && ft_q.size() != 0) e = ft_q.pop_front();
		else if (port == 1 && kernel_q.size() != 0) e = kernel_q.pop_front();
		else if (port == 2 && linear_q.size() != 0) e = linear_q.pop_front();
		else got = 1'b0;
		if (!got) begin
			$display("unexpected beat on the %s output at %0t", name, $time);
			err_count++;
		end else begin
			if (e.has_data) check_data({name, "_data"}, e.data, data);
			check_flag({name, "_last"}, e.last, last);
			check_info({name, "_user"}, e.user, user);
			if (port != 0) check_keep({name, "_keep"}, e.keep, keep);
		end
	endtask

	task automatic drive_cmds();
		int n;
		for (int i = 0; i < n_cmd && !aborted; i++) begin
			@(posedge clk);
			#1;
			cmd_kind = c_kind[i];
			cmd_valid_pkt = c_valid[i];
			cmd_last_row = c_last[i];
			cmd_len = c_len[i];
			cmd_valid = 1'b1;
			n = 0;
			@(negedge clk);
			while (!cmd_ready && !aborted) begin
				n++;
				if (n > TIMEOUT) begin
					$display("timeout: command %0d was never accepted", i);
					aborted = 1'b1;
				end
				@(negedge clk);
			end
			if (!aborted) expect_cmd(i);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// DMA model, answers each request with len beats of base plus index
	task automatic send_beats(input int j);
		int n;
		for (int b = 0; b < int'(c_len[j]) && !aborted; b++) begin
			dma_data = c_base[j] + data_t'(b);
			dma_last = (b == int'(c_len[j]) - 1);
			dma_valid = 1'b1;
			n = 0;
			@(negedge clk);
			while (!dma_ready && !aborted) begin
				n++;
				if (n > TIMEOUT) begin
					$display("timeout: DMA beat %0d of command %0d was never taken", b, j);
					aborted = 1'b1;
				end
				@(negedge clk);
			end
			@(posedge clk);
			#1;
		end
		dma_valid = 1'b0;
		dma_last = 1'b0;
	endtask

	task automatic serve_dma();
		int n;
		for (int j = 0; j < n_cmd && !aborted; j++) begin
			if (c_valid[j]) begin
				n = 0;
				@(posedge clk);
				#1;
				dma_req_ready = pick_ready();
				@(negedge clk);
				while (!(dma_req_valid && dma_req_ready) && !aborted) begin
					n++;
					if (n > TIMEOUT) begin
						$display("timeout: no DMA request came for command %0d", j);
						aborted = 1'b1;
					end
					@(posedge clk);
					#1;
					dma_req_ready = pick_ready();
					@(negedge clk);
				end
				if (!aborted) check_len("dma_req_len", c_len[j], dma_req_len);
				@(posedge clk);
				#1;
				dma_req_ready = 1'b0;
				send_beats(j);
			end
		end
	endtask

	// whole command list once, then drain and count requests
	task automatic run_pass(input int test_no, input logic bp);
		int errs_before;
		int req_before;
		int n_valid;
		int n;
		errs_before = err_count;
		req_before = req_seen;
		bp_en = bp;
		n_valid = 0;
		for (int i = 0; i < n_cmd; i++) begin
			if (c_valid[i]) n_valid++;
		end
		fork
			drive_cmds();
			serve_dma();
		join
		n = 0;
		while (ft_q.size() + kernel_q.size() + linear_q.size() != 0 && !aborted) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("timeout: output beats still missing after the last command");
				aborted = 1'b1;
			end
		end
		@(negedge clk);
		// invalid commands must not reach the DMA
		if (req_seen - req_before != n_valid) begin
			$display("DMA saw %0d requests for %0d valid commands", req_seen - req_before,
				n_valid);
			err_count++;
		end
		check_flag("dma_req_valid", 1'b0, dma_req_valid);
		$display("test %0d %s: %0d commands, %0d errors", test_no,
			bp ? "random back-pressure" : "full rate", n_cmd, err_count - errs_before);
		bp_en = 1'b0;
	endtask

	// output readies change just after the edge
	always @(posedge clk) begin
		#1;
		ft_ready = pick_ready();
		kernel_ready = pick_ready();
		linear_ready = pick_ready();
	end

	// sinks and request monitor look mid-cycle, ahead of the transfer edge
	always @(negedge clk) begin
		if (rst_n && ft_valid && ft_ready) take_beat(0, ft_data, '1, ft_user, ft_last);
		if (rst_n && kernel_valid && kernel_ready)
			take_beat(1, kernel_data, kernel_keep, {1'b0, kernel_user}, kernel_last);
		if (rst_n && linear_valid && linear_ready)
			take_beat(2, linear_data, linear_keep, linear_user, linear_last);
		// each request counts once on its first cycle, taken or not
		if (rst_n && dma_req_valid && !req_open) req_seen++;
		req_open = rst_n && dma_req_valid && !dma_req_ready;
	end

	initial begin
		void'($urandom(32'h98637a02));
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_kind = CMD_FT_ROW;
		cmd_valid_pkt = 1'b0;
		cmd_last_row = 1'b0;
		cmd_len = '0;
		cmd_valid = 1'b0;
		dma_req_ready = 1'b0;
		dma_data = '0;
		dma_keep = '1;
		dma_last = 1'b0;
		dma_valid = 1'b0;
		ft_ready = 1'b1;
		kernel_ready = 1'b1;
		linear_ready = 1'b1;
		load_stim();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		// idle state right after reset
		check_flag("cmd_ready", 1'b1, cmd_ready);
		check_flag("dma_req_valid", 1'b0, dma_req_valid);
		check_flag("ft_valid", 1'b0, ft_valid);
		check_flag("kernel_valid", 1'b0, kernel_valid);
		check_flag("linear_valid", 1'b0, linear_valid);
		$display("test 1 reset state: %0d errors", err_count);
		run_pass(2, 1'b0);
		run_pass(3, 1'b1);
		$display("done: 3 tests, %0d check errors, %0d assertion failures, run %s",
			err_count, conv_in_loader_inst.asserts_inst.fired,
			aborted ? "aborted" : "complete");
		if (err_count == 0 && conv_in_loader_inst.asserts_inst.fired == 0 && !aborted) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: conv_in_stim.txt
# kind (0 row, 1 kernel, 2 linear A, 3 linear B) valid last_row len base_hex
# invalid commands keep a len column that the loader never sees on the DMA side
0 1 0 4 0000000000001000
0 1 1 3 0000000000002000
1 1 0 6 00000000a0000000
1 0 0 5 00000000b0000000
2 1 0 2 0000000030000000
3 1 0 3 0000000040000000
0 0 0 4 0000000050000000
0 0 1 1 0000000060000000
1 1 0 1 0000000070000000
3 0 0 2 0000000080000000
2 1 0 5 1234567800000000
0 1 0 2 fffffffffffffffe
2 0 0 1 0000000090000000
1 0 0 3 00000000c0000000
3 1 0 4 00000000d0000000
0 1 1 7 00000000e0000000

// File: build.f
conv_in_pkg.sv
dispatch_msg_fifo.sv
conv_in_rd_ctrl.sv
axis_gateway_for_conv_in.sv
conv_in_loader.sv
conv_in_loader_asserts.sv
tb_conv_in_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the conv_in_loader testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_conv_in_loader -o sim_tb
# raise the error limit so assertion failures reach the testbench summary
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log
if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
